// File: verilog/controlPkg.sv
package controlPkg;

	////////////////////////////////////////////////////////////
	// Instruction and flag widths
	////////////////////////////////////////////////////////////
	localparam int DataWidth = 16;
	localparam int OpWidth   = 4;
	localparam int RegWidth  = 4;
	localparam int OpExWidth = 4;
	localparam int ImmWidth  = 8;
	localparam int PsrWidth  = 5;

	typedef logic [RegWidth-1:0] regIdx;

	// Return address register for JAL
	localparam regIdx LinkReg = regIdx'(15);

	// Major opcode, inst[15:12]
	typedef enum logic [OpWidth-1:0] {
		opRType = 4'b0000,
		opAndi  = 4'b0001,
		opOri   = 4'b0010,
		opXori  = 4'b0011,
		opOType = 4'b0100,
		opAddi  = 4'b0101,
		opAddui = 4'b0110,
		opSType = 4'b1000,
		opSubi  = 4'b1001,
		opCmpi  = 4'b1011,
		opBcond = 4'b1100,
		opMovi  = 4'b1101,
		opLui   = 4'b1111
	} opcode;

	// Extension field, inst[7:4]; values overlap between classes
	typedef logic [OpExWidth-1:0] opExt;

	// Register class
	localparam opExt exAnd  = 4'b0001;
	localparam opExt exOr   = 4'b0010;
	localparam opExt exXor  = 4'b0011;
	localparam opExt exAdd  = 4'b0101;
	localparam opExt exAddu = 4'b0110;
	localparam opExt exSub  = 4'b1001;
	localparam opExt exCmp  = 4'b1011;
	localparam opExt exMov  = 4'b1101;

	// Other class
	localparam opExt exLoad  = 4'b0000;
	localparam opExt exStor  = 4'b0100;
	localparam opExt exJal   = 4'b1000;
	localparam opExt exJcond = 4'b1100;
	localparam opExt exScond = 4'b1101;

	// Shift class
	localparam opExt exLlshi  = 4'b0000;
	localparam opExt exLrshi  = 4'b0001;
	localparam opExt exAlshui = 4'b0010;
	localparam opExt exArshui = 4'b0011;
	localparam opExt exLsh    = 4'b0100;
	localparam opExt exAshu   = 4'b0110;

	typedef enum logic [3:0] {
		cEq, cNe, cCs, cCc, cHi, cLs, cGt, cLe,
		cFs, cFc, cLo, cHs, cLt, cGe, cUc
	} condCode;

	// Bit positions in the status register
	localparam int FlagC = 0;
	localparam int FlagL = 1;
	localparam int FlagF = 2;
	localparam int FlagZ = 3;
	localparam int FlagN = 4;

	typedef enum logic [3:0] {
		aluAdd, aluAddu, aluSub, aluAnd, aluOr, aluXor,
		aluMov, aluLui, aluSll, aluSrl, aluSla, aluSra
	} aluOp;

	typedef enum logic [1:0] {
		wbLink = 2'd0,
		wbCond = 2'd1,
		wbAlu  = 2'd2,
		wbMem  = 2'd3
	} wbSel;

	typedef enum logic [1:0] {
		phFetch, phDecode, phLoad
	} ctrlPhase;

	// ALU operation of an immediate-form opcode
	function automatic aluOp immAluOp(opcode op);
		aluOp res;
		case (op)
			opAndi:  res = aluAnd;
			opOri:   res = aluOr;
			opXori:  res = aluXor;
			opAddui: res = aluAddu;
			opSubi:  res = aluSub;
			opCmpi:  res = aluSub;
			opMovi:  res = aluMov;
			opLui:   res = aluLui;
			default: res = aluAdd;
		endcase
		return res;
	endfunction

	// ALU operation of a register-form extension
	function automatic aluOp regAluOp(opExt ex);
		aluOp res;
		case (ex)
			exAnd:   res = aluAnd;
			exOr:    res = aluOr;
			exXor:   res = aluXor;
			exAddu:  res = aluAddu;
			exSub:   res = aluSub;
			exCmp:   res = aluSub;
			exMov:   res = aluMov;
			default: res = aluAdd;
		endcase
		return res;
	endfunction

endpackage

// File: verilog/ctrlSequencer.sv
`timescale 1ns/1ps

module ctrlSequencer
	import controlPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     isLoad,
	output ctrlPhase phase
);

	ctrlPhase nextPhase;

	////////////////////////////////////////////////////////////
	// Phase register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			phase <= phFetch;
		end
		else
		begin
			phase <= nextPhase;
		end
	end

	////////////////////////////////////////////////////////////
	// Next phase
	////////////////////////////////////////////////////////////
	always_comb
	begin
		nextPhase = phFetch;
		case (phase)
			phFetch:
			begin
				nextPhase = phDecode;
			end
			phDecode:
			begin
				// LOAD needs one more cycle for the memory data
				if (isLoad)
				begin
					nextPhase = phLoad;
				end
				else
				begin
					nextPhase = phFetch;
				end
			end
			phLoad:
			begin
				nextPhase = phFetch;
			end
			default:
			begin
				nextPhase = phFetch;
			end
		endcase
	end

endmodule

// File: verilog/condEval.sv
`timescale 1ns/1ps

module condEval
	import controlPkg::*;
(
	input  logic [PsrWidth-1:0] psr,
	input  condCode             condSel,
	output logic                condMet
);

	logic flagZ;
	logic flagC;
	logic flagL;
	logic flagN;
	logic flagF;

	assign flagZ = psr[FlagZ];
	assign flagC = psr[FlagC];
	assign flagL = psr[FlagL];
	assign flagN = psr[FlagN];
	assign flagF = psr[FlagF];

	always_comb
	begin
		case (condSel)
			cEq: condMet = flagZ;
			cNe: condMet = !flagZ;
			cCs: condMet = flagC;
			cCc: condMet = !flagC;
			cHi: condMet = flagL;
			cLs: condMet = !flagL;
			cGt: condMet = flagN;
			cLe: condMet = !flagN;
			cFs: condMet = flagF;
			cFc: condMet = !flagF;
			// Compound conditions fold in the zero flag
			cHs: condMet = flagZ | flagL;
			cLo: condMet = !flagZ & !flagL;
			cGe: condMet = flagZ | flagN;
			cLt: condMet = !flagZ & !flagN;
			// Unconditional code and code 15 never hold
			default: condMet = 1'b0;
		endcase
	end

endmodule

// File: verilog/instDecode.sv
`timescale 1ns/1ps

module instDecode
	import controlPkg::*;
(
	input  logic [DataWidth-1:0] inst,
	input  ctrlPhase             phase,
	input  logic                 condMet,
	output condCode              condSel,
	output logic                 isLoad,
	output logic                 branch,
	output logic                 jump,
	output logic                 memcMux,
	output logic                 immMux,
	output logic                 psrEn,
	output logic                 pcEn,
	output logic                 write,
	output logic                 condRslt,
	output wbSel                 wbMux,
	output regIdx                rDst,
	output regIdx                rSrc,
	output logic [ImmWidth-1:0]  immVal,
	output controlPkg::aluOp     aluOp
);

	// Field offsets within the instruction word
	localparam int OpLo  = DataWidth - OpWidth;
	localparam int DstLo = OpLo - RegWidth;
	localparam int ExLo  = DstLo - OpExWidth;

	opcode                opField;
	opExt                 extField;
	regIdx                dstField;
	regIdx                lowNib;
	logic [ImmWidth-1:0]  immField;

	assign opField  = opcode'(inst[OpLo +: OpWidth]);
	assign dstField = inst[DstLo +: RegWidth];
	assign extField = inst[ExLo +: OpExWidth];
	assign lowNib   = inst[RegWidth-1:0];
	assign immField = inst[ImmWidth-1:0];

	assign isLoad = (opField == opOType) && (extField == exLoad);

	// JCOND carries its condition where the others carry rDst
	assign condSel = ((opField == opOType) && (extField == exJcond)) ?
		condCode'(dstField) : condCode'(lowNib);

	always_comb
	begin
		branch   = 1'b0;
		jump     = 1'b0;
		memcMux  = 1'b0;
		immMux   = 1'b0;
		psrEn    = 1'b0;
		pcEn     = 1'b0;
		write    = 1'b0;
		condRslt = 1'b0;
		wbMux    = wbAlu;
		rDst     = '0;
		rSrc     = '0;
		immVal   = '0;
		aluOp    = aluAdd;
		case (phase)
			phDecode:
			begin
				case (opField)
					////////////////////////////////////////////////////////////
					// Immediate ALU forms
					////////////////////////////////////////////////////////////
					opAndi, opOri, opXori, opAddi, opAddui, opSubi, opCmpi, opMovi, opLui:
					begin
						rDst   = dstField;
						immVal = immField;
						aluOp  = immAluOp(opField);
						immMux = 1'b1;
						psrEn  = 1'b1;
						pcEn   = 1'b1;
						write  = (opField != opCmpi);
					end
					////////////////////////////////////////////////////////////
					// Register ALU forms
					////////////////////////////////////////////////////////////
					opRType:
					begin
						case (extField)
							exAnd, exOr, exXor, exAdd, exAddu, exSub, exCmp, exMov:
							begin
								rDst  = dstField;
								rSrc  = lowNib;
								aluOp = regAluOp(extField);
								psrEn = 1'b1;
								pcEn  = 1'b1;
								write = (extField != exCmp);
							end
							default: ;
						endcase
					end
					////////////////////////////////////////////////////////////
					// Memory, conditional set and jumps
					////////////////////////////////////////////////////////////
					opOType:
					begin
						case (extField)
							exLoad:
							begin
								// Address phase only, PC waits for phLoad
								rSrc    = lowNib;
								memcMux = 1'b1;
							end
							exStor:
							begin
								rDst    = dstField;
								rSrc    = lowNib;
								memcMux = 1'b1;
								pcEn    = 1'b1;
							end
							exScond:
							begin
								rDst     = dstField;
								wbMux    = wbCond;
								write    = 1'b1;
								pcEn     = 1'b1;
								condRslt = condMet;
							end
							exJcond:
							begin
								rSrc = lowNib;
								pcEn = 1'b1;
								jump = condMet;
							end
							exJal:
							begin
								jump  = 1'b1;
								rDst  = LinkReg;
								rSrc  = lowNib;
								write = 1'b1;
								wbMux = wbLink;
								pcEn  = 1'b1;
							end
							default: ;
						endcase
					end
					opBcond:
					begin
						immVal = immField;
						immMux = 1'b1;
						pcEn   = 1'b1;
						branch = condMet;
					end
					////////////////////////////////////////////////////////////
					// Shifts, no flag update
					////////////////////////////////////////////////////////////
					opSType:
					begin
						case (extField)
							exLsh, exAshu:
							begin
								rDst  = dstField;
								rSrc  = lowNib;
								aluOp = (extField == exLsh) ? aluSll : aluSla;
								write = 1'b1;
								pcEn  = 1'b1;
							end
							exLlshi, exLrshi, exAlshui, exArshui:
							begin
								rDst   = dstField;
								immVal = {{(ImmWidth-RegWidth){1'b0}}, lowNib};
								write  = 1'b1;
								pcEn   = 1'b1;
								case (extField)
									exLlshi:  aluOp = aluSll;
									exLrshi:  aluOp = aluSrl;
									exAlshui: aluOp = aluSla;
									default:  aluOp = aluSra;
								endcase
							end
							default: ;
						endcase
					end
					default: ;
				endcase
			end
			phLoad:
			begin
				// Memory data goes back to rDst
				rDst    = dstField;
				rSrc    = lowNib;
				memcMux = 1'b1;
				write   = 1'b1;
				wbMux   = wbMem;
				pcEn    = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/cr16Controller.sv
`timescale 1ns/1ps

module cr16Controller
	import controlPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic [PsrWidth-1:0]  psr,
	input  logic [DataWidth-1:0] inst,
	output logic                 branch,
	output logic                 jump,
	output logic                 memcMux,
	output logic                 immMux,
	output logic                 psrEn,
	output logic                 pcEn,
	output logic                 write,
	output logic                 condRslt,
	output wbSel                 wbMux,
	output regIdx                rDst,
	output regIdx                rSrc,
	output logic [ImmWidth-1:0]  immVal,
	output controlPkg::aluOp     aluOp
);

	ctrlPhase phase;
	logic     isLoad;
	condCode  condSel;
	logic     condMet;

	ctrlSequencer sequencer (
		.clk    (clk),
		.rst    (rst),
		.isLoad (isLoad),
		.phase  (phase)
	);

	// One evaluator shared by SCOND, JCOND and BCOND
	condEval conditions (
		.psr     (psr),
		.condSel (condSel),
		.condMet (condMet)
	);

	instDecode decoder (
		.inst     (inst),
		.phase    (phase),
		.condMet  (condMet),
		.condSel  (condSel),
		.isLoad   (isLoad),
		.branch   (branch),
		.jump     (jump),
		.memcMux  (memcMux),
		.immMux   (immMux),
		.psrEn    (psrEn),
		.pcEn     (pcEn),
		.write    (write),
		.condRslt (condRslt),
		.wbMux    (wbMux),
		.rDst     (rDst),
		.rSrc     (rSrc),
		.immVal   (immVal),
		.aluOp    (aluOp)
	);

endmodule

// File: verification/controllerVectors.svh
`ifndef CONTROLLER_VECTORS_SVH
`define CONTROLLER_VECTORS_SVH

// Control outputs in DUT port order
typedef struct packed {
	logic                branch;
	logic                jump;
	logic                memcMux;
	logic                immMux;
	logic                psrEn;
	logic                pcEn;
	logic                write;
	logic                condRslt;
	wbSel                wbMux;
	regIdx               rDst;
	regIdx               rSrc;
	logic [ImmWidth-1:0] immVal;
	aluOp                alu;
} ctrlOut;

// Which output carries the condition result
localparam int KindPlain = 0;
localparam int KindScond = 1;
localparam int KindBcond = 2;
localparam int KindJcond = 3;

typedef struct {
	string                name;
	logic [DataWidth-1:0] inst;
	logic [PsrWidth-1:0]  psr;
	int                   kind;
	condCode              code;
	ctrlOut               dec;
	logic                 load;
	ctrlOut               ld;
} vecRow;

vecRow vec[$];

function automatic ctrlOut ctl(
	input logic br, jp, mc, im, pe, pc, wr, cr,
	input wbSel wb,
	input regIdx d, s,
	input logic [ImmWidth-1:0] iv,
	input aluOp op
);
	return ctrlOut'({br, jp, mc, im, pe, pc, wr, cr, wb, d, s, iv, op});
endfunction

function automatic ctrlOut idleOut();
	return ctl(0, 0, 0, 0, 0, 0, 0, 0, wbAlu, 0, 0, 0, aluAdd);
endfunction

task automatic addRow(input string name, input logic [DataWidth-1:0] word, input ctrlOut dec);
	vecRow r;
	r.name = name;
	r.inst = word;
	r.psr = 5'h1F;
	r.kind = KindPlain;
	r.code = cEq;
	r.dec = dec;
	r.load = 1'b0;
	r.ld = idleOut();
	vec.push_back(r);
endtask

// Random flags, expected bit filled in when the row runs
task automatic addCond(input string name, input logic [DataWidth-1:0] word, input int kind,
	input logic [3:0] cc, input ctrlOut dec);
	addRow(name, word, dec);
	vec[vec.size()-1].psr = PsrWidth'($random(seed));
	vec[vec.size()-1].kind = kind;
	vec[vec.size()-1].code = condCode'(cc);
endtask

task automatic buildTable();
	logic [3:0] cc;
	// Immediate forms
	addRow("andi", 16'h135A, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'h3, 0, 8'h5A, aluAnd));
	addRow("ori", 16'h2933, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'h9, 0, 8'h33, aluOr));
	addRow("xori", 16'h3A44, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'hA, 0, 8'h44, aluXor));
	addRow("addi", 16'h517F, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'h1, 0, 8'h7F, aluAdd));
	addRow("addui", 16'h62FF, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'h2, 0, 8'hFF, aluAddu));
	addRow("subi", 16'h9A01, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'hA, 0, 8'h01, aluSub));
	addRow("cmpi", 16'hB4C3, ctl(0, 0, 0, 1, 1, 1, 0, 0, wbAlu, 4'h4, 0, 8'hC3, aluSub));
	addRow("movi", 16'hD7EE, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'h7, 0, 8'hEE, aluMov));
	addRow("lui", 16'hF812, ctl(0, 0, 0, 1, 1, 1, 1, 0, wbAlu, 4'h8, 0, 8'h12, aluLui));
	// Register forms
	addRow("and", 16'h0215, ctl(0, 0, 0, 0, 1, 1, 1, 0, wbAlu, 4'h2, 4'h5, 0, aluAnd));
	addRow("add", 16'h0356, ctl(0, 0, 0, 0, 1, 1, 1, 0, wbAlu, 4'h3, 4'h6, 0, aluAdd));
	addRow("addu", 16'h0764, ctl(0, 0, 0, 0, 1, 1, 1, 0, wbAlu, 4'h7, 4'h4, 0, aluAddu));
	addRow("sub", 16'h0497, ctl(0, 0, 0, 0, 1, 1, 1, 0, wbAlu, 4'h4, 4'h7, 0, aluSub));
	addRow("cmp", 16'h05B8, ctl(0, 0, 0, 0, 1, 1, 0, 0, wbAlu, 4'h5, 4'h8, 0, aluSub));
	addRow("mov", 16'h06D9, ctl(0, 0, 0, 0, 1, 1, 1, 0, wbAlu, 4'h6, 4'h9, 0, aluMov));
	// Shifts leave the flags alone
	addRow("llshi", 16'h8307, ctl(0, 0, 0, 0, 0, 1, 1, 0, wbAlu, 4'h3, 0, 8'h07, aluSll));
	addRow("lrshi", 16'h841F, ctl(0, 0, 0, 0, 0, 1, 1, 0, wbAlu, 4'h4, 0, 8'h0F, aluSrl));
	addRow("alshui", 16'h852A, ctl(0, 0, 0, 0, 0, 1, 1, 0, wbAlu, 4'h5, 0, 8'h0A, aluSla));
	addRow("arshui", 16'h863C, ctl(0, 0, 0, 0, 0, 1, 1, 0, wbAlu, 4'h6, 0, 8'h0C, aluSra));
	addRow("lsh", 16'h8745, ctl(0, 0, 0, 0, 0, 1, 1, 0, wbAlu, 4'h7, 4'h5, 0, aluSll));
	addRow("ashu", 16'h8866, ctl(0, 0, 0, 0, 0, 1, 1, 0, wbAlu, 4'h8, 4'h6, 0, aluSla));
	// Memory and link
	addRow("load", 16'h4A03, ctl(0, 0, 1, 0, 0, 0, 0, 0, wbAlu, 0, 4'h3, 0, aluAdd));
	vec[vec.size()-1].load = 1'b1;
	vec[vec.size()-1].ld = ctl(0, 0, 1, 0, 0, 1, 1, 0, wbMem, 4'hA, 4'h3, 0, aluAdd);
	addRow("stor", 16'h4B42, ctl(0, 0, 1, 0, 0, 1, 0, 0, wbAlu, 4'hB, 4'h2, 0, aluAdd));
	addRow("jal", 16'h4C89, ctl(0, 1, 0, 0, 0, 1, 1, 0, wbLink, 4'hF, 4'h9, 0, aluAdd));
	// Codes with no meaning
	addRow("op7", 16'h7123, idleOut());
	addRow("opA", 16'hA456, idleOut());
	addRow("opE", 16'hE789, idleOut());
	addRow("rExt0", 16'h0100, idleOut());
	addRow("oExt2", 16'h4F20, idleOut());
	addRow("sExt9", 16'h8F90, idleOut());
	for (int c = 0; c < 16; c++)
	begin
		cc = 4'(c);
		addCond($sformatf("scond%0d", c), {4'h4, ~cc, 4'hD, cc}, KindScond, cc,
			ctl(0, 0, 0, 0, 0, 1, 1, 0, wbCond, ~cc, 0, 0, aluAdd));
		addCond($sformatf("bcond%0d", c), {4'hC, 4'h0, 4'h9, cc}, KindBcond, cc,
			ctl(0, 0, 0, 1, 0, 1, 0, 0, wbAlu, 0, 0, {4'h9, cc}, aluAdd));
		addCond($sformatf("jcond%0d", c), {4'h4, cc, 4'hC, cc ^ 4'h5}, KindJcond, cc,
			ctl(0, 0, 0, 0, 0, 1, 0, 0, wbAlu, 0, cc ^ 4'h5, 0, aluAdd));
	end
endtask

`endif

// File: verification/controllerTb.sv
`timescale 1ns/1ps

module controllerTb
	import controlPkg::*;
;

	logic                 clk;
	logic                 rst;
	logic [PsrWidth-1:0]  psr;
	logic [DataWidth-1:0] inst;
	logic                 branch;
	logic                 jump;
	logic                 memcMux;
	logic                 immMux;
	logic                 psrEn;
	logic                 pcEn;
	logic                 write;
	logic                 condRslt;
	wbSel                 wbMux;
	regIdx                rDst;
	regIdx                rSrc;
	logic [ImmWidth-1:0]  immVal;
	aluOp                 aluCode;

	integer seed;
	int     errors;
	int     rowsOk;
	int     cycles;
	int     cycleLimit;

	`include "controllerVectors.svh"

	cr16Controller DUT (
		.clk      (clk),
		.rst      (rst),
		.psr      (psr),
		.inst     (inst),
		.branch   (branch),
		.jump     (jump),
		.memcMux  (memcMux),
		.immMux   (immMux),
		.psrEn    (psrEn),
		.pcEn     (pcEn),
		.write    (write),
		.condRslt (condRslt),
		.wbMux    (wbMux),
		.rDst     (rDst),
		.rSrc     (rSrc),
		.immVal   (immVal),
		.aluOp    (aluCode)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Condition table of the ISA, flags C L F Z N at bits 0 to 4
	function automatic logic condHolds(input condCode code, input logic [PsrWidth-1:0] flags);
		logic c;
		logic l;
		logic f;
		logic z;
		logic n;
		c = flags[0];
		l = flags[1];
		f = flags[2];
		z = flags[3];
		n = flags[4];
		case (code)
			cEq: return z;
			cNe: return !z;
			cCs: return c;
			cCc: return !c;
			cHi: return l;
			cLs: return !l;
			cGt: return n;
			cLe: return !n;
			cFs: return f;
			cFc: return !f;
			cHs: return z || l;
			cLo: return !(z || l);
			cGe: return z || n;
			cLt: return !(z || n);
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkOut(input string rowName, input string stage, input ctrlOut exp,
		inout logic ok);
		ctrlOut got;
		got = ctrlOut'({branch, jump, memcMux, immMux, psrEn, pcEn, write, condRslt,
			wbMux, rDst, rSrc, immVal, aluCode});
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at %0t: %s %s cycle expected %h got %h",
				$time, rowName, stage, exp, got);
			errors++;
			ok = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// One instruction, entered 1 ns into its fetch cycle
	////////////////////////////////////////////////////////////
	task automatic runRow(input vecRow r);
		ctrlOut exp;
		logic   hold;
		logic   ok;
		ok = 1'b1;
		inst = r.inst;
		psr = r.psr;
		exp = r.dec;
		hold = condHolds(r.code, r.psr);
		case (r.kind)
			KindScond: exp.condRslt = hold;
			KindBcond: exp.branch = hold;
			KindJcond: exp.jump = hold;
			default: ;
		endcase
		#17;
		checkOut(r.name, "fetch", idleOut(), ok);
		@(posedge clk);
		#18;
		checkOut(r.name, "decode", exp, ok);
		if (r.load)
		begin
			@(posedge clk);
			#18;
			checkOut(r.name, "load", r.ld, ok);
		end
		@(posedge clk);
		#1;
		if (ok)
		begin
			rowsOk++;
		end
		$display("%-8s %s", r.name, ok ? "ok" : "MISMATCH");
	endtask

	initial
	begin
		rst = 1'b0;
		inst = '0;
		psr = '0;
		seed = 32'hc540_cb37;
		errors = 0;
		rowsOk = 0;
		buildTable();
		cycleLimit = 3 * vec.size() + 8 + 20;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		foreach (vec[i])
		begin
			runRow(vec[i]);
		end
		$display("%0d rows, %0d correct, %0d check errors", vec.size(), rowsOk, errors);
		if (errors == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog
	initial
	begin
		cycles = 0;
		wait (cycleLimit > 0);
		while (cycles < cycleLimit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
		$display("tests failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+verification
verilog/controlPkg.sv
verilog/ctrlSequencer.sv
verilog/condEval.sv
verilog/instDecode.sv
verilog/cr16Controller.sv
verification/controllerTb.sv

// File: Bender.yml
package:
  name: cr16_controller

sources:
  - files:
      - verilog/controlPkg.sv
      - verilog/ctrlSequencer.sv
      - verilog/condEval.sv
      - verilog/instDecode.sv
      - verilog/cr16Controller.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/controllerTb.sv
